// ==== permute_cases.txt ====
// Columns: bot, mask, last flag, output count, first output given, expected first output
// First word is the number of cases, all values in hex
21
3c5a96e17b2d48f0a5c3e1f0968d7b24 ffffff 0 18 1 3c5a96e17b2d48f0a5c3e1f0968d7b24
13579bdf02468ace8642fdb9ace02468 ffffff 1 18 1 13579bdf02468ace8642fdb9ace02468
0f0e0d0c0b0a09080706050403020100 000001 0 01 1 0f0e0d0c0b0a09080706050403020100
0f0e0d0c0b0a09080706050403020100 000002 0 01 1 0f0e0d0c070605040b0a090803020100
0f0e0d0c0b0a09080706050403020100 000004 0 01 1 0f0e0b0a0d0c09080706030205040100
0f0e0d0c0b0a09080706050403020100 000008 0 01 1 0f0e0b0a070603020d0c090805040100
0f0e0d0c0b0a09080706050403020100 000010 0 01 1 0f0e07060d0c05040b0a030209080100
0f0e0d0c0b0a09080706050403020100 000020 1 01 1 0f0e07060b0a03020d0c050409080100
0f0e0d0c0b0a09080706050403020100 000040 0 01 1 0f0d0e0c0b090a080705060403010200
0f0e0d0c0b0a09080706050403020100 000080 0 01 1 0f0d0e0c070506040b090a0803010200
0f0e0d0c0b0a09080706050403020100 000100 0 01 1 0f0d0b090e0c0a080705030106040200
0f0e0d0c0b0a09080706050403020100 000200 0 01 1 0f0d0b09070503010e0c0a0806040200
0f0e0d0c0b0a09080706050403020100 000400 0 01 1 0f0d07050e0c06040b0903010a080200
0f0e0d0c0b0a09080706050403020100 000800 0 01 1 0f0d07050b0903010e0c06040a080200
0f0e0d0c0b0a09080706050403020100 001000 0 01 1 0f0b0d090e0a0c080703050106020400
0f0e0d0c0b0a09080706050403020100 002000 0 01 1 0f0b0d09070305010e0a0c0806020400
0f0e0d0c0b0a09080706050403020100 004000 0 01 1 0f0b0e0a0d090c080703060205010400
0f0e0d0c0b0a09080706050403020100 008000 0 01 1 0f0b0e0a070306020d090c0805010400
0f0e0d0c0b0a09080706050403020100 010000 0 01 1 0f0b07030d0905010e0a06020c080400
0f0e0d0c0b0a09080706050403020100 020000 0 01 1 0f0b07030e0a06020d0905010c080400
0f0e0d0c0b0a09080706050403020100 040000 0 01 1 0f070d050b0309010e060c040a020800
0f0e0d0c0b0a09080706050403020100 080000 0 01 1 0f070d050e060c040b0309010a020800
0f0e0d0c0b0a09080706050403020100 100000 0 01 1 0f070b030d0509010e060a020c040800
0f0e0d0c0b0a09080706050403020100 200000 0 01 1 0f070b030e060a020d0509010c040800
0f0e0d0c0b0a09080706050403020100 400000 0 01 1 0f070e060d050c040b030a0209010800
0f0e0d0c0b0a09080706050403020100 800000 1 01 1 0f070e060b030a020d050c0409010800
f0e1d2c3b4a5968778695a4b3c2d1e0f 000000 1 00 0 0
f0e1d2c3b4a5968778695a4b3c2d1e0f 000000 0 00 0 0
f0e1d2c3b4a5968778695a4b3c2d1e0f 0c0303 1 06 1 f0e1d2c3b4a5968778695a4b3c2d1e0f
00ff00ff0f0f0f0f3333333355555555 800001 0 02 1 00ff00ff0f0f0f0f3333333355555555
00ff00ff0f0f0f0f3333333355555555 000fff 0 0c 0 0
13579bdf02468ace8642fdb9ace02468 555555 0 0c 0 0
3c5a96e17b2d48f0a5c3e1f0968d7b24 3f0000 1 06 0 0

// ==== vlog.f ====
+incdir+.
botDataPkg.sv
permuteCtrlPkg.sv
botFifo.sv
permuteSelector.sv
botPermute1234.sv
botPermuterTop.sv
botPermuterChecker.sv
tbBotPermuter.sv

// ==== tbBotPermuter.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "permute_consts.svh"

module tbBotPermuter
    import botDataPkg::*, permuteCtrlPkg::*;
();

    localparam int MAX_CASES = 64;
    localparam int WORDS_PER_CASE = 6;   // bot, mask, last, count, first given, first
    localparam int QUIET_CYCLES = 10;    // Window that catches stray outputs at the end

    typedef struct packed {
        logic isBatch;                   // batchDone mark rather than an output
        bot_t bot;
    } expItem_t;

    logic clk;
    logic rst;
    logic write;
    botInput_t wrData;
    logic almostFull;
    logic slowDown;
    logic permutedValid;
    bot_t permutedBot;
    logic batchDone;

    logic [127:0] caseWords [WORDS_PER_CASE*MAX_CASES+1];
    expItem_t expected [$];
    string orders [`NUM_SETS];           // Four letters per permInSet
    logic [31:0] rng;

    botPermuterTop dut0 (
        .clk          (clk),
        .rst          (rst),
        .write        (write),
        .wrData       (wrData),
        .almostFull   (almostFull),
        .slowDown     (slowDown),
        .permutedValid(permutedValid),
        .permutedBot  (permutedBot),
        .batchDone    (batchDone)
    );

    always #2 clk = ~clk;

    task automatic stopWithFailure(string why);
        $display("%s", why);
        $display("test failed");
        $fatal(1);
    endtask

    task automatic compareBot(string name, bot_t got, bot_t exp);
        if (got !== exp) begin
            stopWithFailure($sformatf("** Error at %0t ns: %s is %h, expected %h",
                $time, name, got.flat, exp.flat));
        end
    endtask

    task automatic compareFlag(string name, logic got, logic exp);
        if (got !== exp) begin
            stopWithFailure($sformatf("** Error at %0t ns: %s is %b, expected %b",
                $time, name, got, exp));
        end
    endtask

    function automatic logic [31:0] xorshift(logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Output minterm m reads the input minterm whose named variables carry the bits of m
    function automatic bot_t permuteRef(bot_t b, int s, int p);
        bot_t r;
        int src;
        byte name;
        for (int m = 0; m < `BOT_ENTRIES; m++) begin
            src = 0;
            for (int i = 0; i < `NUM_SETS; i++) begin
                name = orders[s][p*4 + i];
                if (m[i]) begin
                    src |= 1 << (name - "a");
                end
            end
            r.entries[m] = b.entries[src];
        end
        return r;
    endfunction

    // Expected outputs in issue order with a batch mark after each last-flagged bot
    task automatic buildModel(input int numCases, output int totalOutputs);
        int base;
        int produced;
        expItem_t item;
        bot_t inBot;
        bot_t fileFirst;
        permMask_t mask;
        totalOutputs = 0;
        for (int c = 0; c < numCases; c++) begin
            base = 1 + WORDS_PER_CASE*c;
            inBot.flat = caseWords[base];
            mask = caseWords[base+1][$bits(permMask_t)-1:0];
            fileFirst.flat = caseWords[base+5];
            produced = 0;
            for (int p = 0; p < `PERMS_PER_SET; p++) begin
                for (int s = 0; s < `NUM_SETS; s++) begin
                    if (mask[s*`PERMS_PER_SET + p]) begin
                        item.isBatch = 1'b0;
                        item.bot = permuteRef(inBot, s, p);
                        if (produced == 0 && caseWords[base+4] != 0) begin
                            compareBot($sformatf("first permutedBot of case %0d", c),
                                item.bot, fileFirst);
                        end
                        expected.push_back(item);
                        produced++;
                    end
                end
            end
            if (produced != int'(caseWords[base+3])) begin
                stopWithFailure($sformatf("case %0d gives %0d outputs but the file expects %0d",
                    c, produced, int'(caseWords[base+3])));
            end
            if (caseWords[base+2][0]) begin
                item.isBatch = 1'b1;
                item.bot = '0;
                expected.push_back(item);
            end
            totalOutputs += produced;
        end
    endtask

    task automatic checkOutputs();
        expItem_t item;
        if (permutedValid && batchDone) begin
            stopWithFailure("permutedValid and batchDone were high in the same cycle");
        end else if (permutedValid || batchDone) begin
            if (expected.size() == 0) begin
                stopWithFailure("the DUT produced a result when none was left to expect");
            end else begin
                item = expected.pop_front();
                compareFlag("batchDone", batchDone, item.isBatch);
                if (!item.isBatch) begin
                    compareBot("permutedBot", permutedBot, item.bot);
                end
            end
        end
    endtask

    initial begin
        int numCases;
        int totalOutputs;
        int limit;
        int cycles;
        int nextCase;
        int quiet;
        int base;
        logic sawAlmostFull;
        clk = 1'b0;
        rst = 1'b1;
        write = 1'b0;
        wrData = '0;
        slowDown = 1'b0;
        rng = 32'd63170;
        orders[0] = "abcdabdcacbdacdbadbcadcb";
        orders[1] = "bacdbadcbcadbcdabdacbdca";
        orders[2] = "cbadcbdacabdcadbcdbacdab";
        orders[3] = "dbcadbacdcbadcabdabcdacb";
        $readmemh("permute_cases.txt", caseWords);
        numCases = int'(caseWords[0]);
        buildModel(numCases, totalOutputs);
        limit = (totalOutputs + numCases) * 4 + 200;    // Slack covers reset and the drain
        cycles = 0;
        nextCase = 0;
        quiet = 0;
        sawAlmostFull = 1'b0;

        repeat (4) @(negedge clk);
        compareFlag("almostFull", almostFull, 1'b0);    // Reset leaves the FIFO empty
        rst = 1'b0;

        while (quiet < QUIET_CYCLES) begin
            @(negedge clk);
            cycles++;
            checkOutputs();
            if (cycles > limit) begin
                stopWithFailure($sformatf("timeout after %0d cycles, %0d results never came",
                    cycles, expected.size()));
            end
            sawAlmostFull |= almostFull;
            rng = xorshift(rng);
            slowDown = (rng[1:0] == 2'b00);      // High about one cycle in four
            if (nextCase < numCases && !almostFull) begin
                base = 1 + WORDS_PER_CASE*nextCase;
                write = 1'b1;
                wrData.bot.flat = caseWords[base];
                wrData.mask = caseWords[base+1][$bits(permMask_t)-1:0];
                wrData.last = caseWords[base+2][0];
                nextCase++;
            end else begin
                write = 1'b0;
            end
            if (nextCase == numCases && expected.size() == 0) begin
                quiet++;
            end
        end

        if (!sawAlmostFull) begin
            stopWithFailure("almostFull never rose during the write burst");
        end else begin
            $display("test passed");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== botPermuterChecker.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "permute_consts.svh"

module botPermuterChecker
    import botDataPkg::*;
(
    input  logic clk,
    input  logic rst,
    input  logic slowDown,
    input  logic permutedValid,
    input  logic batchDone,
    input  bot_t permutedBot
);

    // Outputs leave reset idle
    assert property (@(posedge clk) $fell(rst) |-> !permutedValid && !batchDone)
        else $error("permutedValid or batchDone high in the first cycle after reset");

    // A stalled edge leaves a gap two edges later
    assert property (@(posedge clk) disable iff (rst) slowDown |-> ##2 !permutedValid)
        else $error("permutedValid high two edges after slowDown");

    assert property (@(posedge clk) disable iff (rst)
        permutedValid |-> !$isunknown(permutedBot))
        else $error("permutedBot has unknown bits while permutedValid is high");

endmodule

bind botPermuterTop botPermuterChecker checker0 (
    .clk          (clk),
    .rst          (rst),
    .slowDown     (slowDown),
    .permutedValid(permutedValid),
    .batchDone    (batchDone),
    .permutedBot  (permutedBot)
);

`default_nettype wire

// ==== botPermuterTop.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "permute_consts.svh"

module botPermuterTop
    import botDataPkg::*, permuteCtrlPkg::*;
(
    input  logic      clk,
    input  logic      rst,

    // Write side
    input  logic      write,
    input  botInput_t wrData,
    output logic      almostFull,

    // Read side
    input  logic      slowDown,
    output logic      permutedValid,
    output bot_t      permutedBot,
    output logic      batchDone
);

    logic accept;
    logic fifoEmpty;
    logic headLast;
    logic selValid;
    logic selBatchDone;
    permMask_t headMask;
    permSel_t sel;
    bot_t storedBot;

    botFifo #(
        .DEPTH_LOG2        (`FIFO_DEPTH_LOG2),
        .ALMOST_FULL_MARGIN(`ALMOST_FULL_MARGIN)
    ) fifo0 (
        .clk       (clk),
        .rst       (rst),
        .write     (write),
        .wrData    (wrData),
        .almostFull(almostFull),
        .accept    (accept),
        .empty     (fifoEmpty),
        .headMask  (headMask),
        .headLast  (headLast),
        .storedBot (storedBot)
    );

    permuteSelector selector0 (
        .clk      (clk),
        .rst      (rst),
        .headMask (headMask),
        .headLast (headLast),
        .empty    (fifoEmpty),
        .accept   (accept),
        .slowDown (slowDown),
        .sel      (sel),
        .selValid (selValid),
        .batchDone(selBatchDone)
    );

    botPermute1234 permuter0 (
        .clk          (clk),
        .sel          (sel),
        .selValid     (selValid),
        .storedBot    (storedBot),
        .permutedValid(permutedValid),
        .batchDoneIn  (selBatchDone),
        .batchDone    (batchDone),
        .permutedBot  (permutedBot)
    );

endmodule

`default_nettype wire

// ==== botPermute1234.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "permute_consts.svh"

module botPermute1234
    import botDataPkg::*, permuteCtrlPkg::*;
(
    input  logic     clk,
    input  permSel_t sel,
    input  logic     selValid,
    input  bot_t     storedBot,
    output logic     permutedValid,
    input  logic     batchDoneIn,
    output logic     batchDone,
    output bot_t     permutedBot
);

    localparam int NUM_PAIRS = 6;        // Minterms with exactly two variables set
    localparam int TOP = `BOT_ENTRIES - 1;

    localparam varIdx_t A = 0;
    localparam varIdx_t B = 1;
    localparam varIdx_t C = 2;
    localparam varIdx_t D = 3;

    // Pair order ab, ac, ad, bc, bd, cd, so entry 5-i is the complement of entry i
    localparam logic [$clog2(`BOT_ENTRIES)-1:0] PAIR_MINTERM [NUM_PAIRS] =
        '{4'b0011, 4'b0101, 4'b1001, 4'b0110, 4'b1010, 4'b1100};

    typedef varIdx_t [`NUM_SETS-1:0] order_t;   // Input variable at each output position
    typedef logic [$clog2(NUM_PAIRS)-1:0] pairIdx_t;

    function automatic order_t seq(varIdx_t p0, varIdx_t p1, varIdx_t p2, varIdx_t p3);
        return {p3, p2, p1, p0};
    endfunction

    function automatic order_t permOrder(permSel_t s);
        case ({s.set, s.permInSet})
            5'o00: return seq(A, B, C, D);
            5'o01: return seq(A, B, D, C);
            5'o02: return seq(A, C, B, D);
            5'o03: return seq(A, C, D, B);
            5'o04: return seq(A, D, B, C);
            5'o05: return seq(A, D, C, B);
            5'o10: return seq(B, A, C, D);
            5'o11: return seq(B, A, D, C);
            5'o12: return seq(B, C, A, D);
            5'o13: return seq(B, C, D, A);
            5'o14: return seq(B, D, A, C);
            5'o15: return seq(B, D, C, A);
            5'o20: return seq(C, B, A, D);
            5'o21: return seq(C, B, D, A);
            5'o22: return seq(C, A, B, D);
            5'o23: return seq(C, A, D, B);
            5'o24: return seq(C, D, B, A);
            5'o25: return seq(C, D, A, B);
            5'o30: return seq(D, B, C, A);
            5'o31: return seq(D, B, A, C);
            5'o32: return seq(D, C, B, A);
            5'o33: return seq(D, C, A, B);
            5'o34: return seq(D, A, B, C);
            5'o35: return seq(D, A, C, B);
            default: return seq(A, B, C, D);
        endcase
    endfunction

    // Position of the pair {x, y} in PAIR_MINTERM
    function automatic pairIdx_t pairIndex(varIdx_t x, varIdx_t y);
        pairIdx_t idx;
        idx = '0;
        for (int i = 0; i < NUM_PAIRS; i++) begin
            if (PAIR_MINTERM[i] == ((4'b1 << x) | (4'b1 << y))) begin
                idx = pairIdx_t'(i);
            end
        end
        return idx;
    endfunction

    order_t order;
    varIdx_t [`NUM_SETS-1:0] singleLane;
    pairIdx_t [2:0] pairLane;              // Outputs ab, ac, ad
    botEntry_t [`NUM_SETS-1:0] oneIn;      // Input minterms 0001, 0010, 0100, 1000
    botEntry_t [`NUM_SETS-1:0] threeIn;    // Their complements
    botEntry_t [NUM_PAIRS-1:0] twoIn;

    assign order = permOrder(sel);

    always_ff @(posedge clk) begin
        if (selValid) begin
            singleLane <= order;
            for (int k = 1; k < `NUM_SETS; k++) begin
                pairLane[k-1] <= pairIndex(order[0], order[k]);
            end
        end
        permutedValid <= selValid;          // Aligned with the lane stage
        batchDone <= batchDoneIn;
    end

    // Weight classes of the input
    always_comb begin
        for (int j = 0; j < `NUM_SETS; j++) begin
            oneIn[j] = storedBot.entries[1 << j];
            threeIn[j] = storedBot.entries[TOP - (1 << j)];
        end
        for (int i = 0; i < NUM_PAIRS; i++) begin
            twoIn[i] = storedBot.entries[PAIR_MINTERM[i]];
        end
    end

    always_comb begin
        permutedBot.entries[0] = storedBot.entries[0];        // No variable set
        permutedBot.entries[TOP] = storedBot.entries[TOP];    // All set
        for (int k = 0; k < `NUM_SETS; k++) begin
            permutedBot.entries[1 << k] = oneIn[singleLane[k]];
            permutedBot.entries[TOP - (1 << k)] = threeIn[singleLane[k]];
        end
        // Complement outputs take the complement pair
        for (int q = 0; q < 3; q++) begin
            permutedBot.entries[PAIR_MINTERM[q]] = twoIn[pairLane[q]];
            permutedBot.entries[PAIR_MINTERM[NUM_PAIRS-1-q]] =
                twoIn[pairIdx_t'(NUM_PAIRS-1) - pairLane[q]];
        end
    end

endmodule

`default_nettype wire

// ==== permuteSelector.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "permute_consts.svh"

module permuteSelector
    import permuteCtrlPkg::*;
(
    input  logic      clk,
    input  logic      rst,

    // FIFO side
    input  permMask_t headMask,
    input  logic      headLast,
    input  logic      empty,
    output logic      accept,

    // Permuter side
    input  logic      slowDown,
    output permSel_t  sel,
    output logic      selValid,
    output logic      batchDone
);

    // One section per permInSet, one bit per set inside it
    typedef logic [`PERMS_PER_SET-1:0][`NUM_SETS-1:0] sections_t;

    sections_t sections;           // Selections still to issue for the current bot
    sections_t headSections;
    sections_t clearedSections;
    permSel_t pick;
    logic anyLeft;
    logic drained;
    logic doneNow;
    logic storedLast;

    // Regroup the head mask so that permInSet is the outer order
    always_comb begin
        for (int p = 0; p < `PERMS_PER_SET; p++) begin
            for (int s = 0; s < `NUM_SETS; s++) begin
                headSections[p][s] = headMask[s*`PERMS_PER_SET + p];
            end
        end
    end

    assign anyLeft = |sections;

    // First non-empty section, then the first set bit inside it
    always_comb begin
        pick = '0;
        for (int p = `PERMS_PER_SET-1; p >= 0; p--) begin
            if (sections[p] != '0) begin
                pick.permInSet = permIdx_t'(p);
            end
        end
        for (int s = `NUM_SETS-1; s >= 0; s--) begin
            if (sections[pick.permInSet][s]) begin
                pick.set = varIdx_t'(s);
            end
        end
    end

    always_comb begin
        clearedSections = sections;
        clearedSections[pick.permInSet][pick.set] = 1'b0;
    end

    // The last selection has to leave the lane stage before storedBot may change
    assign drained = !anyLeft && !selValid;
    assign accept = drained && !empty && !slowDown;
    assign doneNow = drained && storedLast && !slowDown;   // Moving past a last-flagged bot

    always_ff @(posedge clk) begin
        if (rst) begin
            sections <= '0;
            storedLast <= 1'b0;
            selValid <= 1'b0;
            batchDone <= 1'b0;
        end else begin
            selValid <= anyLeft && !slowDown;
            batchDone <= doneNow;

            if (accept) begin
                sections <= headSections;
            end else if (anyLeft && !slowDown) begin
                sections <= clearedSections;      // Held while slowed down
            end

            if (accept) begin
                storedLast <= headLast;
            end else if (doneNow) begin
                storedLast <= 1'b0;               // Idle with an empty FIFO
            end
        end
    end

    always_ff @(posedge clk) begin
        if (anyLeft && !slowDown) begin
            sel <= pick;
        end
    end

endmodule

`default_nettype wire

// ==== botFifo.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "permute_consts.svh"

module botFifo
    import botDataPkg::*, permuteCtrlPkg::*;
#(
    parameter int DEPTH_LOG2 = `FIFO_DEPTH_LOG2,
    parameter int ALMOST_FULL_MARGIN = `ALMOST_FULL_MARGIN
) (
    input  logic      clk,
    input  logic      rst,

    // Write side
    input  logic      write,
    input  botInput_t wrData,
    output logic      almostFull,

    // Selector side
    input  logic      accept,      // Pops the head entry
    output logic      empty,
    output permMask_t headMask,
    output logic      headLast,
    output bot_t      storedBot    // Bot of the most recently accepted entry
);

    localparam int DEPTH = 1 << DEPTH_LOG2;
    localparam int PTR_W = DEPTH_LOG2 + 1;   // Wrap bit tells full from empty

    typedef logic [PTR_W-1:0] ptr_t;

    botInput_t mem [DEPTH];
    ptr_t wrPtr;
    ptr_t rdPtr;
    ptr_t count;
    ptr_t countNext;
    ptr_t freeNext;
    botInput_t head;

    assign count = wrPtr - rdPtr;
    assign countNext = count + ptr_t'(write) - ptr_t'(accept);
    assign freeNext = ptr_t'(DEPTH) - countNext;
    assign empty = (count == '0);

    // Show-ahead view of the head, the selector needs its mask before accepting
    assign head = mem[rdPtr[DEPTH_LOG2-1:0]];
    assign headMask = head.mask;
    assign headLast = head.last;

    always_ff @(posedge clk) begin
        if (rst) begin
            wrPtr <= '0;
            rdPtr <= '0;
            almostFull <= 1'b0;
        end else begin
            if (write) begin
                wrPtr <= wrPtr + 1'b1;
            end
            if (accept) begin
                rdPtr <= rdPtr + 1'b1;
            end
            almostFull <= freeNext < ptr_t'(ALMOST_FULL_MARGIN);   // From next occupancy
        end
    end

    always_ff @(posedge clk) begin
        if (write) begin
            mem[wrPtr[DEPTH_LOG2-1:0]] <= wrData;
        end
    end

    // Held until the following accept, the permuter reads it for every selection
    always_ff @(posedge clk) begin
        if (accept) begin
            storedBot <= head.bot;
        end
    end

endmodule

`default_nettype wire

// ==== permuteCtrlPkg.sv ====
`default_nettype none

`include "permute_consts.svh"

package permuteCtrlPkg;

    // Bit set*PERMS_PER_SET+permInSet requests that permutation
    typedef logic [`NUM_SETS*`PERMS_PER_SET-1:0] permMask_t;

    typedef logic [$clog2(`NUM_SETS)-1:0] varIdx_t;        // Variable a..d, also the set
    typedef logic [$clog2(`PERMS_PER_SET)-1:0] permIdx_t;  // 0 to 5

    // One permutation of the fixed order
    typedef struct packed {
        varIdx_t set;          // Leading variable
        permIdx_t permInSet;
    } permSel_t;

    // Write side of the FIFO
    typedef struct packed {
        botDataPkg::bot_t bot;
        permMask_t mask;
        logic last;            // Last bot of its batch
    } botInput_t;

endpackage

`default_nettype wire

// ==== botDataPkg.sv ====
`default_nettype none

`include "permute_consts.svh"

package botDataPkg;

    // One minterm entry of a truth table
    typedef logic [`ENTRY_WIDTH-1:0] botEntry_t;

    // Stored and moved as one flat word, permuted entry by entry
    typedef union packed {
        logic [`BOT_ENTRIES*`ENTRY_WIDTH-1:0] flat;
        botEntry_t [`BOT_ENTRIES-1:0] entries;     // Indexed by minterm, bit 0 is variable a
    } bot_t;

endpackage

`default_nettype wire

// ==== permute_consts.svh ====
`ifndef PERMUTE_CONSTS_SVH
`define PERMUTE_CONSTS_SVH

// Truth table geometry
`define ENTRY_WIDTH 8           // Bits per minterm entry
`define BOT_ENTRIES 16          // One entry per minterm of four variables

// Permutation space
`define NUM_SETS 4              // Choice of leading variable, also the variable count
`define PERMS_PER_SET 6         // Orders of the remaining three variables

// Input FIFO
`define FIFO_DEPTH_LOG2 5
`define ALMOST_FULL_MARGIN 4    // almostFull rises below this many free slots

`endif
